//--- run_sim.sh
#!/usr/bin/env bash
# Build the data memory path testbench with Verilator, run it and scan the log

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --top-module dmem_ctrl_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vdmem_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
exit 1

//--- sim/dmem_ctrl_tb.sv
// dmem_ctrl testbench with clock, pattern reader, bus responder, compare tasks and timeout
`default_nettype none

module dmem_ctrl_tb
  import dmem_pkg::*;
();

  localparam addr_t ROM_BASE    = 32'h0000_0000;
  localparam addr_t ROM_SIZE    = 32'h0001_0000;
  localparam addr_t RAM_BASE    = 32'h1000_0000;
  localparam addr_t RAM_SIZE    = 32'h0001_0000;
  localparam addr_t IO_BASE     = 32'h8000_0000;
  localparam addr_t IO_SIZE     = 32'h0000_1000;
  localparam int    ACK_TIMEOUT = 16;
  localparam int    MAX_PAT     = 64;

  logic      clk_i, rst_n_i;
  logic      mem_req_i, mem_we_i, mem_ack_o, mem_err_o, mem_misaligned_o;
  addr_t     mem_adr_i, biu_adr_o;
  mem_size_t mem_size_i, biu_size_o;
  data_t     mem_d_i, mem_q_o, biu_d_o, biu_q_i;
  prv_t      st_prv_i;
  logic      biu_stb_o, biu_stb_ack_i, biu_we_o, biu_ack_i, biu_err_i;
  prot_t     biu_prot_o;

  // Pattern table with one entry per file line
  logic      p_we [MAX_PAT];
  mem_size_t p_size [MAX_PAT];
  addr_t     p_adr [MAX_PAT];
  data_t     p_d [MAX_PAT];
  prv_t      p_prv [MAX_PAT];
  int        p_stb_dly [MAX_PAT];
  int        p_ack_dly [MAX_PAT];   // -1 when the bus never answers
  data_t     p_q [MAX_PAT];
  logic      p_berr [MAX_PAT];
  logic      p_exp_ack [MAX_PAT];
  logic      p_exp_err [MAX_PAT];
  logic      p_exp_mis [MAX_PAT];
  data_t     p_exp_q [MAX_PAT];

  int          npat, errors, checks, cur_pat, cycles, limit;
  logic        running;
  logic [31:0] rng;

  dmem_ctrl #(
    .ROM_BASE ( ROM_BASE ), .ROM_SIZE ( ROM_SIZE ), .RAM_BASE    ( RAM_BASE    ),
    .RAM_SIZE ( RAM_SIZE ), .IO_BASE  ( IO_BASE  ), .IO_SIZE     ( IO_SIZE     ),
    .ACK_TIMEOUT ( ACK_TIMEOUT )
  ) dmem_ctrl_i (
    .clk_i ( clk_i ), .rst_n_i ( rst_n_i ), .mem_req_i ( mem_req_i ),
    .mem_adr_i ( mem_adr_i ), .mem_size_i ( mem_size_i ), .mem_we_i ( mem_we_i ),
    .mem_d_i ( mem_d_i ), .st_prv_i ( st_prv_i ), .mem_q_o ( mem_q_o ),
    .mem_ack_o ( mem_ack_o ), .mem_err_o ( mem_err_o ), .mem_misaligned_o ( mem_misaligned_o ),
    .biu_stb_o ( biu_stb_o ), .biu_stb_ack_i ( biu_stb_ack_i ), .biu_adr_o ( biu_adr_o ),
    .biu_size_o ( biu_size_o ), .biu_we_o ( biu_we_o ), .biu_prot_o ( biu_prot_o ),
    .biu_d_o ( biu_d_o ), .biu_q_i ( biu_q_i ), .biu_ack_i ( biu_ack_i ),
    .biu_err_i ( biu_err_i )
  );

  always #50 clk_i = ~clk_i;         // 100 unit period

  // Run length guard
  always @(posedge clk_i)
  begin
    if (running)
    begin
      cycles <= cycles + 1;
      if (cycles >= limit)
      begin
        $display("Timeout, access %0d still open after %0d cycles", cur_pat, cycles);
        $display("%0d accesses, %0d checks, %0d errors", npat, checks, errors + 1);
        $display("sim failed");
        $finish;
      end
    end
  end

  ////////////////////////////////////////
  // Reference rules

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic in_region(input addr_t adr, input addr_t base, input addr_t size);
    return (adr >= base) && ((adr - base) < size);
  endfunction

  // Misaligned, unmapped or a ROM store never reaches the bus
  function automatic logic rejected_access(input addr_t adr, input mem_size_t size,
                                           input logic we);
    logic rom;
    logic mis;
    rom = in_region(adr, ROM_BASE, ROM_SIZE);
    mis = (size == SIZE_HALF && adr[0]) || (size == SIZE_WORD && adr[1:0] != 2'b00);
    return mis || (rom && we) || !(rom || in_region(adr, RAM_BASE, RAM_SIZE)
                                       || in_region(adr, IO_BASE, IO_SIZE));
  endfunction

  ////////////////////////////////////////
  // Compare tasks

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s = %h, expected %h, access %0d", name, got, exp, cur_pat);
    end
  endtask

  task automatic check_size(input string name, input mem_size_t got, input mem_size_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s = %h, expected %h, access %0d", name, got, exp, cur_pat);
    end
  endtask

  task automatic check_prot(input string name, input prot_t got, input prot_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s = %h, expected %h, access %0d", name, got, exp, cur_pat);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s = %h, expected %h, access %0d", name, got, exp, cur_pat);
    end
  endtask

  ////////////////////////////////////////
  // Pattern file

  task automatic read_patterns();
    int               fd;
    int               cnt;
    int               stb;
    int               dly;
    logic [8*200-1:0] line;
    logic [8*8-1:0]   ack_tok;
    logic [31:0]      f_we, f_size, f_adr, f_d, f_prv, f_q, f_berr;
    logic [31:0]      f_ack, f_err, f_mis, f_eq;
    fd = $fopen("sim/dmem_patterns.txt", "r");
    if (fd == 0)
      $display("Cannot open the pattern file sim/dmem_patterns.txt");
    else
    begin
      while (!$feof(fd) && npat < MAX_PAT)
      begin
        line = '0;
        void'($fgets(line, fd));
        cnt = $sscanf(line, "%h %h %h %h %h %d %s %h %h %h %h %h %h", f_we, f_size,
                      f_adr, f_d, f_prv, stb, ack_tok, f_q, f_berr, f_ack, f_err,
                      f_mis, f_eq);
        if (cnt == 13)                      // Comments and blank lines skipped
        begin
          dly = -1;
          if (ack_tok[31:0] != "none")
            void'($sscanf(ack_tok, "%d", dly));
          p_we[npat]      = f_we[0];
          p_size[npat]    = mem_size_t'(f_size[1:0]);
          p_adr[npat]     = f_adr;
          p_d[npat]       = f_d;
          p_prv[npat]     = f_prv[1:0];
          p_stb_dly[npat] = stb;
          p_ack_dly[npat] = dly;
          p_q[npat]       = f_q;
          p_berr[npat]    = f_berr[0];
          p_exp_ack[npat] = f_ack[0];
          p_exp_err[npat] = f_err[0];
          p_exp_mis[npat] = f_mis[0];
          p_exp_q[npat]   = f_eq;
          npat++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // One access with bus responder

  task automatic run_access(input int i);
    int    n;
    int    stb_cnt;
    int    ack_left;
    logic  stb_taken;
    logic  done;
    logic  rej;
    data_t wdata;
    prot_t exp_prot;
    rej = rejected_access(p_adr[i], p_size[i], p_we[i]);
    if (p_prv[i] == PRV_U)               // User level data access
      exp_prot = PROT_DATA | PROT_USER;
    else
      exp_prot = PROT_DATA | PROT_PRIVILEGED;
    rng      = xorshift32(rng);
    wdata    = p_we[i] ? p_d[i] : rng;   // Loads carry junk store data
    cur_pat  = i;
    @(posedge clk_i);
    #10;
    mem_req_i  = 1'b1;
    mem_adr_i  = p_adr[i];
    mem_size_i = p_size[i];
    mem_we_i   = p_we[i];
    mem_d_i    = wdata;
    st_prv_i   = p_prv[i];
    n          = 0;
    stb_cnt    = 0;
    ack_left   = -1;
    stb_taken  = 1'b0;
    done       = 1'b0;
    while (!done)
    begin
      @(posedge clk_i);
      #10;
      n++;
      mem_req_i     = 1'b0;              // One cycle strobe
      biu_stb_ack_i = 1'b0;
      biu_ack_i     = 1'b0;
      biu_err_i     = 1'b0;
      rng           = xorshift32(rng);
      biu_q_i       = rng;               // Junk outside the data ack
      if (rej)
        check_flag("biu_stb_o", biu_stb_o, 1'b0);
      else if (n == 1)
        check_flag("biu_stb_o", biu_stb_o, 1'b0);
      else if (n == 2)
        check_flag("biu_stb_o", biu_stb_o, 1'b1);
      // Fields stable for every strobe cycle
      if (biu_stb_o && !stb_taken)
      begin
        check_data("biu_adr_o", biu_adr_o, p_adr[i]);
        check_size("biu_size_o", biu_size_o, p_size[i]);
        check_flag("biu_we_o", biu_we_o, p_we[i]);
        check_data("biu_d_o", biu_d_o, wdata);
        check_prot("biu_prot_o", biu_prot_o, exp_prot);
        if (stb_cnt == p_stb_dly[i])
        begin
          biu_stb_ack_i = 1'b1;
          stb_taken     = 1'b1;
          ack_left      = p_ack_dly[i];
        end
        stb_cnt++;
      end
      if (stb_taken && ack_left == 0)    // Data phase ends
      begin
        biu_ack_i = !p_berr[i];
        biu_err_i = p_berr[i];
        biu_q_i   = p_q[i];
      end
      if (ack_left >= 0)
        ack_left--;
      if (mem_ack_o || mem_err_o)
      begin
        done = 1'b1;
        if (n < 2 || (rej && n != 2))
        begin
          errors++;
          $display("Access %0d answered %0d cycles after its request", i, n);
        end
        check_flag("mem_ack_o", mem_ack_o, p_exp_ack[i]);
        check_flag("mem_err_o", mem_err_o, p_exp_err[i]);
        check_flag("mem_misaligned_o", mem_misaligned_o, p_exp_mis[i]);
        check_data("mem_q_o", mem_q_o, p_exp_q[i]);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial
  begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    mem_req_i     = 1'b0;
    mem_adr_i     = '0;
    mem_size_i    = SIZE_BYTE;
    mem_we_i      = 1'b0;
    mem_d_i       = '0;
    st_prv_i      = PRV_U;
    biu_stb_ack_i = 1'b0;
    biu_q_i       = '0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    errors        = 0;
    checks        = 0;
    npat          = 0;
    cur_pat       = -1;
    cycles        = 0;
    running       = 1'b0;
    rng           = 32'he259;
    read_patterns();
    limit = npat * (ACK_TIMEOUT + 10);
    repeat (16) @(posedge clk_i);
    #10;
    check_flag("biu_stb_o", biu_stb_o, 1'b0);        // Quiet out of reset
    check_flag("mem_ack_o", mem_ack_o, 1'b0);
    check_flag("mem_err_o", mem_err_o, 1'b0);
    check_flag("mem_misaligned_o", mem_misaligned_o, 1'b0);
    check_data("mem_q_o", mem_q_o, '0);
    rst_n_i = 1'b1;
    if (npat == 0)
    begin
      errors++;
      $display("No access patterns were read");
    end
    running = 1'b1;
    for (int i = 0; i < npat; i++)
      run_access(i);
    running = 1'b0;
    $display("%0d accesses, %0d checks, %0d errors", npat, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/dmem_patterns.txt
# we size adr wdata prv stb_dly ack_dly bus_q bus_err | exp_ack exp_err exp_mis exp_q
# size 0 byte, 1 half, 2 word; ack_dly none means no data ack; delays in cycles, decimal
# Plain RAM, IO and ROM accesses
0 2 10000000 00000000 3 0 1    a5a5a5a5 0 1 0 0 a5a5a5a5
1 2 10000004 12345678 3 1 0    00000000 0 1 0 0 a5a5a5a5
0 1 10000102 00000000 0 0 0    0000beef 0 1 0 0 0000beef
1 0 80000003 000000c3 0 2 2    00000000 0 1 0 0 0000beef
0 2 80000ffc 00000000 3 0 3    cafef00d 0 1 0 0 cafef00d
0 2 00000100 00000000 1 0 1    11223344 0 1 0 0 11223344
# Misaligned half and word
0 1 10000001 00000000 0 0 0    00000000 0 0 1 1 11223344
1 2 10000002 deadbeef 3 0 0    00000000 0 0 1 1 11223344
0 2 80000001 00000000 1 0 0    00000000 0 0 1 1 11223344
# ROM write and unmapped addresses
1 2 00000100 55aa55aa 3 0 0    00000000 0 0 1 0 11223344
0 2 20000000 00000000 3 0 0    00000000 0 0 1 0 11223344
1 0 10010000 00000011 0 0 0    00000000 0 0 1 0 11223344
0 0 80001000 00000000 3 0 0    00000000 0 0 1 0 11223344
0 0 ffffffff 00000000 0 0 0    00000000 0 0 1 0 11223344
# Bus error answers
0 2 10000010 00000000 3 0 2    99999999 1 0 1 0 11223344
1 2 10000014 0badf00d 0 1 0    00000000 1 0 1 0 11223344
# Watchdog, no data ack, then a normal read
0 2 10000020 00000000 3 0 none 00000000 0 0 1 0 11223344
0 2 10000020 00000000 3 0 0    76543210 0 1 0 0 76543210
# Watchdog, strobe ack held back, then a normal read
1 2 80000010 a0a0a0a0 0 20 0   00000000 0 0 1 0 76543210
0 0 80000010 00000000 0 0 0    000000aa 0 1 0 0 000000aa
# Long but legal wait states
0 1 10000040 00000000 0 10 3   00005a5a 0 1 0 0 00005a5a
0 0 10000043 00000000 1 2 1    000000ff 0 1 0 0 000000ff

//--- source/dmem_access_buf.sv
// Access buffer, holds one CPU load or store until it is answered
`default_nettype none

module dmem_access_buf
  import dmem_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,

  // CPU request
  input  wire logic      req_i,
  input  wire addr_t     adr_i,
  input  wire mem_size_t size_i,
  input  wire logic      we_i,
  input  wire data_t     d_i,

  input  wire logic      clr_i,   // Free buffer, from FSM

  // Buffered request
  output      logic      req_o,
  output      addr_t     adr_o,
  output      mem_size_t size_o,
  output      logic      we_o,
  output      data_t     d_o
);

  // Pending flag, new request wins over clear
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      req_o <= 1'b0;
    else if (req_i)
      req_o <= 1'b1;
    else if (clr_i)
      req_o <= 1'b0;
  end

  // Request fields, held for the life of the access
  always_ff @(posedge clk_i)
  begin
    if (req_i)
    begin
      adr_o  <= adr_i;
      size_o <= size_i;
      we_o   <= we_i;
      d_o    <= d_i;   // Only meaningful for stores
    end
  end

endmodule

`default_nettype wire

//--- source/dmem_access_chk.sv
// Misalignment and region attribute check of the buffered access
`default_nettype none

module dmem_access_chk
  import dmem_pkg::*;
#(
  parameter addr_t ROM_BASE = 32'h0000_0000,
  parameter addr_t ROM_SIZE = 32'h0001_0000,
  parameter addr_t RAM_BASE = 32'h1000_0000,
  parameter addr_t RAM_SIZE = 32'h0001_0000,
  parameter addr_t IO_BASE  = 32'h8000_0000,
  parameter addr_t IO_SIZE  = 32'h0000_1000
)
(
  input  wire logic      req_i,
  input  wire addr_t     adr_i,
  input  wire mem_size_t size_i,
  input  wire logic      we_i,

  output      logic      misaligned_o,
  output      logic      fault_o
);

  logic misaligned;
  logic in_rom;
  logic in_ram;
  logic in_io;
  logic unmapped;
  logic rom_write;

  ////////////////////////////////////////
  // Alignment

  always_comb
  begin
    unique case (size_i)
      SIZE_BYTE: misaligned = 1'b0;          // Bytes always aligned
      SIZE_HALF: misaligned = adr_i[0];
      SIZE_WORD: misaligned = |adr_i[1:0];
      default:   misaligned = 1'b1;          // Unknown size, reject
    endcase
  end

  ////////////////////////////////////////
  // Region match

  // Offset compare, wraps below base to a large value
  assign in_rom = (adr_i - ROM_BASE) < ROM_SIZE;
  assign in_ram = (adr_i - RAM_BASE) < RAM_SIZE;
  assign in_io  = (adr_i - IO_BASE)  < IO_SIZE;

  assign unmapped  = ~(in_rom | in_ram | in_io);
  assign rom_write = in_rom & we_i;          // ROM is read-only

  // Quiet while no request pending
  assign misaligned_o = req_i & misaligned;
  assign fault_o      = req_i & (misaligned | unmapped | rom_write);

endmodule

`default_nettype wire

//--- source/dmem_ack_timer.sv
// Watchdog counter for bus wait states
`default_nettype none

module dmem_ack_timer
  import dmem_pkg::*;
#(
  parameter int ACK_TIMEOUT = 16   // Cycles before giving up
)
(
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic run_i,         // Bus transfer outstanding
  output      logic expired_o
);

  localparam tmr_cnt_t LIMIT = tmr_cnt_t'(ACK_TIMEOUT - 1);

  tmr_cnt_t cnt;

  // Count run cycles, hold at limit
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || !run_i)
      cnt <= '0;
    else if (cnt != LIMIT)
      cnt <= cnt + 1'b1;
  end

  // High in the last allowed cycle
  assign expired_o = run_i & (cnt == LIMIT);

endmodule

`default_nettype wire

//--- source/dmem_biu_fsm.sv
// BIU transfer state machine and CPU response generation
`default_nettype none

module dmem_biu_fsm
  import dmem_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,

  // Buffered request and its check result
  input  wire logic      buf_req_i,
  input  wire addr_t     buf_adr_i,
  input  wire mem_size_t buf_size_i,
  input  wire logic      buf_we_i,
  input  wire data_t     buf_d_i,
  input  wire logic      chk_misaligned_i,
  input  wire logic      chk_fault_i,
  input  wire prv_t      prv_i,

  input  wire logic      tmr_expired_i,  // Watchdog

  // Bus answers
  input  wire logic      biu_stb_ack_i,
  input  wire data_t     biu_q_i,
  input  wire logic      biu_ack_i,
  input  wire logic      biu_err_i,

  output      logic      buf_clr_o,
  output      logic      tmr_run_o,

  // Bus request
  output      logic      biu_stb_o,
  output      addr_t     biu_adr_o,
  output      mem_size_t biu_size_o,
  output      logic      biu_we_o,
  output      prot_t     biu_prot_o,
  output      data_t     biu_d_o,

  // CPU response
  output      data_t     mem_q_o,
  output      logic      mem_ack_o,
  output      logic      mem_err_o,
  output      logic      mem_misaligned_o
);

  biu_state_t state, state_nxt;
  logic       rsp_ack, rsp_err, rsp_mis;  // Next response pulse
  logic       bus_done;

  assign bus_done = biu_ack_i | biu_err_i;

  ////////////////////////////////////////
  // Next state

  always_comb
  begin
    state_nxt = state;
    rsp_ack   = 1'b0;
    rsp_err   = 1'b0;
    rsp_mis   = 1'b0;

    unique case (state)
      ST_IDLE:
        if (buf_req_i)
        begin
          if (chk_fault_i)
          begin
            rsp_err   = 1'b1;             // Rejected, never hits the bus
            rsp_mis   = chk_misaligned_i;
            state_nxt = ST_RESP;
          end
          else
            state_nxt = ST_STB;
        end
      ST_STB:
        if (biu_stb_ack_i && bus_done)
        begin
          rsp_ack   = biu_ack_i & ~biu_err_i; // Error wins
          rsp_err   = biu_err_i;
          state_nxt = ST_RESP;
        end
        else if (biu_stb_ack_i)
          state_nxt = ST_WAIT;
        else if (tmr_expired_i)
        begin
          rsp_err   = 1'b1;               // Strobe never taken
          state_nxt = ST_RESP;
        end
      ST_WAIT:
        if (bus_done || tmr_expired_i)
        begin
          rsp_ack   = biu_ack_i & ~biu_err_i;
          rsp_err   = biu_err_i | ~biu_ack_i; // Bus error or timeout
          state_nxt = ST_RESP;
        end
      ST_RESP: state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Registers

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state            <= ST_IDLE;
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
      mem_q_o          <= '0;
    end
    else
    begin
      state            <= state_nxt;
      mem_ack_o        <= rsp_ack;
      mem_err_o        <= rsp_err;
      mem_misaligned_o <= rsp_mis;
      if (rsp_ack && !buf_we_i)
        mem_q_o <= biu_q_i;             // Keep last read data otherwise
    end
  end

  // Protection bits sampled when the strobe starts
  always_ff @(posedge clk_i)
  begin
    if (state == ST_IDLE && buf_req_i)
      biu_prot_o <= PROT_DATA | ((prv_i == PRV_U) ? PROT_USER : PROT_PRIVILEGED);
  end

  assign biu_stb_o  = state == ST_STB;
  assign tmr_run_o  = (state == ST_STB) || (state == ST_WAIT);
  assign buf_clr_o  = state == ST_RESP;   // Free buffer with response

  // Fields straight from the buffer, stable while pending
  assign biu_adr_o  = buf_adr_i;
  assign biu_size_o = buf_size_i;
  assign biu_we_o   = buf_we_i;
  assign biu_d_o    = buf_d_i;

endmodule

`default_nettype wire

//--- source/dmem_ctrl.sv
// Data memory access path top level, buffer, check, bus FSM and watchdog
`default_nettype none

module dmem_ctrl
  import dmem_pkg::*;
#(
  parameter addr_t ROM_BASE    = 32'h0000_0000,
  parameter addr_t ROM_SIZE    = 32'h0001_0000,
  parameter addr_t RAM_BASE    = 32'h1000_0000,
  parameter addr_t RAM_SIZE    = 32'h0001_0000,
  parameter addr_t IO_BASE     = 32'h8000_0000,
  parameter addr_t IO_SIZE     = 32'h0000_1000,
  parameter int    ACK_TIMEOUT = 16
)
(
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,

  // CPU side
  input  wire logic      mem_req_i,
  input  wire addr_t     mem_adr_i,
  input  wire mem_size_t mem_size_i,
  input  wire logic      mem_we_i,
  input  wire data_t     mem_d_i,
  input  wire prv_t      st_prv_i,
  output      data_t     mem_q_o,
  output      logic      mem_ack_o,
  output      logic      mem_err_o,
  output      logic      mem_misaligned_o,

  // BIU port
  output      logic      biu_stb_o,
  input  wire logic      biu_stb_ack_i,
  output      addr_t     biu_adr_o,
  output      mem_size_t biu_size_o,
  output      logic      biu_we_o,
  output      prot_t     biu_prot_o,
  output      data_t     biu_d_o,
  input  wire data_t     biu_q_i,
  input  wire logic      biu_ack_i,
  input  wire logic      biu_err_i
);

  ////////////////////////////////////////
  // Internal wires

  logic      buf_req, buf_we, buf_clr;
  addr_t     buf_adr;
  mem_size_t buf_size;
  data_t     buf_d;
  logic      chk_misaligned, chk_fault;
  logic      tmr_run, tmr_expired;

  ////////////////////////////////////////
  // Instances

  dmem_access_buf u_buf (
    .clk_i   ( clk_i      ), .rst_n_i ( rst_n_i    ),
    .req_i   ( mem_req_i  ), .adr_i   ( mem_adr_i  ),
    .size_i  ( mem_size_i ), .we_i    ( mem_we_i   ),
    .d_i     ( mem_d_i    ), .clr_i   ( buf_clr    ),
    .req_o   ( buf_req    ), .adr_o   ( buf_adr    ),
    .size_o  ( buf_size   ), .we_o    ( buf_we     ),
    .d_o     ( buf_d      )
  );

  dmem_access_chk #(
    .ROM_BASE ( ROM_BASE ), .ROM_SIZE ( ROM_SIZE ),
    .RAM_BASE ( RAM_BASE ), .RAM_SIZE ( RAM_SIZE ),
    .IO_BASE  ( IO_BASE  ), .IO_SIZE  ( IO_SIZE  )
  ) u_chk (
    .req_i        ( buf_req        ), .adr_i   ( buf_adr   ),
    .size_i       ( buf_size       ), .we_i    ( buf_we    ),
    .misaligned_o ( chk_misaligned ), .fault_o ( chk_fault )
  );

  dmem_biu_fsm u_fsm (
    .clk_i            ( clk_i            ), .rst_n_i         ( rst_n_i         ),
    .buf_req_i        ( buf_req          ), .buf_adr_i       ( buf_adr         ),
    .buf_size_i       ( buf_size         ), .buf_we_i        ( buf_we          ),
    .buf_d_i          ( buf_d            ), .chk_misaligned_i( chk_misaligned  ),
    .chk_fault_i      ( chk_fault        ), .prv_i           ( st_prv_i        ),
    .tmr_expired_i    ( tmr_expired      ), .biu_stb_ack_i   ( biu_stb_ack_i   ),
    .biu_q_i          ( biu_q_i          ), .biu_ack_i       ( biu_ack_i       ),
    .biu_err_i        ( biu_err_i        ), .buf_clr_o       ( buf_clr         ),
    .tmr_run_o        ( tmr_run          ), .biu_stb_o       ( biu_stb_o       ),
    .biu_adr_o        ( biu_adr_o        ), .biu_size_o      ( biu_size_o      ),
    .biu_we_o         ( biu_we_o         ), .biu_prot_o      ( biu_prot_o      ),
    .biu_d_o          ( biu_d_o          ), .mem_q_o         ( mem_q_o         ),
    .mem_ack_o        ( mem_ack_o        ), .mem_err_o       ( mem_err_o       ),
    .mem_misaligned_o ( mem_misaligned_o )
  );

  dmem_ack_timer #(.ACK_TIMEOUT ( ACK_TIMEOUT )) u_tmr (
    .clk_i ( clk_i   ), .rst_n_i   ( rst_n_i     ),
    .run_i ( tmr_run ), .expired_o ( tmr_expired )
  );

endmodule

`default_nettype wire

//--- source/dmem_pkg.sv
// Data memory path widths, size and privilege types, BIU protection bits, FSM states
`default_nettype none

package dmem_pkg;

  ////////////////////////////////////////
  // Widths

  localparam int XLEN = 32;                 // Address and data width

  typedef logic [XLEN-1:0] addr_t;          // Byte address
  typedef logic [XLEN-1:0] data_t;          // Data word

  // Access size, same encoding on CPU and BIU side
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_t;

  ////////////////////////////////////////
  // Protection

  typedef logic [2:0] prot_t;               // BIU protection bits

  localparam prot_t PROT_DATA       = 3'b001; // Data, not instruction
  localparam prot_t PROT_USER       = 3'b000; // User level access
  localparam prot_t PROT_PRIVILEGED = 3'b010;

  typedef logic [1:0] prv_t;                // Privilege level
  localparam prv_t PRV_U = 2'b00;           // User mode

  ////////////////////////////////////////
  // Bus FSM and watchdog

  typedef enum logic [1:0] {
    ST_IDLE, // Waiting for buffered request
    ST_STB,  // Strobe out, waiting for strobe ack
    ST_WAIT, // Waiting for data ack or error
    ST_RESP  // Response pulse to CPU
  } biu_state_t;

  typedef logic [7:0] tmr_cnt_t;            // Watchdog count

endpackage

`default_nettype wire

//--- sources.f
source/dmem_pkg.sv
source/dmem_access_buf.sv
source/dmem_access_chk.sv
source/dmem_biu_fsm.sv
source/dmem_ack_timer.sv
source/dmem_ctrl.sv
sim/dmem_ctrl_tb.sv
